//--- logic/rv_core_pkg.sv
package rv_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int shamt_w    = $clog2(xlen);

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_lui = 7'b0110111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // Register format
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } insn_r_t;

    // Immediate format
    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } insn_i_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] insn;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic                  rd_wren;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic                  use_imm;
        alu_op_e               alu_op;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
    } dec_ex_t;

    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic                  rd_wren;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } ex_wb_t;

    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic                  rd_wren;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } retire_t;

    typedef struct packed {
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
    } rf_read_t;

endpackage

//--- logic/rv_core_top.sv
module rv_core_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  rv_core_pkg::issue_t  issue_i,
    output rv_core_pkg::retire_t retire_o
);
    import rv_core_pkg::*;

    dec_ex_t               dec_ex;
    ex_wb_t                ex_wb;
    rf_read_t              rf_read;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;

    // Decode and register read
    rv_decode i_decode (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .issue_i    (issue_i),
        .rf_read_i  (rf_read),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .dec_ex_o   (dec_ex)
    );

    // ALU with forwarding from its own output register
    rv_execute i_execute (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .dec_ex_i (dec_ex),
        .ex_wb_o  (ex_wb)
    );

    // Register file and retire
    rv_writeback i_writeback (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ex_wb_i    (ex_wb),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rf_read_o  (rf_read),
        .retire_o   (retire_o)
    );

endmodule

//--- logic/rv_decode.sv
module rv_decode (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  rv_core_pkg::issue_t                 issue_i,
    input  rv_core_pkg::rf_read_t               rf_read_i,
    output logic [rv_core_pkg::reg_addr_w-1:0]  rs1_addr_o,
    output logic [rv_core_pkg::reg_addr_w-1:0]  rs2_addr_o,
    output rv_core_pkg::dec_ex_t                dec_ex_o
);
    import rv_core_pkg::*;

    insn_u   insn;
    logic    known_op;
    logic    illegal;
    dec_ex_t dec_ex_d;
    dec_ex_t data_q;
    logic    valid_q;
    logic    illegal_q;
    logic    rd_wren_q;

    // Same funct3 table for register and immediate forms
    function automatic alu_op_e alu_from_funct3(logic [2:0] funct3, logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign insn       = issue_i.insn;
    assign rs1_addr_o = insn.r.rs1;
    assign rs2_addr_o = insn.r.rs2;

    always_comb begin
        dec_ex_d          = '0;
        dec_ex_d.rd       = insn.r.rd;
        dec_ex_d.rs1      = insn.r.rs1;
        dec_ex_d.rs2      = insn.r.rs2;
        dec_ex_d.rs1_data = rf_read_i.rs1_data;
        dec_ex_d.rs2_data = rf_read_i.rs2_data;
        // I immediate, sign extended
        dec_ex_d.imm      = {{(xlen-12){insn.i.imm12[11]}}, insn.i.imm12};
        dec_ex_d.alu_op   = alu_add;
        known_op          = 1'b1;
        illegal           = 1'b0;

        case (insn.r.opcode)
            op_reg: begin
                dec_ex_d.alu_op = alu_from_funct3(insn.r.funct3, insn.r.funct7[5]);
                // Alternate encoding only exists for sub and sra
                if (insn.r.funct7 == 7'b0100000) begin
                    illegal = (insn.r.funct3 != 3'b000) && (insn.r.funct3 != 3'b101);
                end else begin
                    illegal = (insn.r.funct7 != 7'b0000000);
                end
            end
            op_imm: begin
                dec_ex_d.use_imm = 1'b1;
                dec_ex_d.alu_op  = alu_from_funct3(insn.r.funct3,
                                                   (insn.r.funct3 == 3'b101) &&
                                                   insn.r.funct7[5]);
                // Shift amount shares the word with funct7
                if (insn.r.funct3 == 3'b001) begin
                    illegal = (insn.r.funct7 != 7'b0000000);
                end else if (insn.r.funct3 == 3'b101) begin
                    illegal = (insn.r.funct7 != 7'b0000000) &&
                              (insn.r.funct7 != 7'b0100000);
                end
            end
            op_lui: begin
                dec_ex_d.use_imm = 1'b1;
                dec_ex_d.alu_op  = alu_pass_b;
                dec_ex_d.imm     = {insn.i.imm12, insn.i.rs1, insn.i.funct3, 12'b0};
            end
            default: begin
                known_op = 1'b0;
                illegal  = 1'b1;
            end
        endcase

        // Idle cycles become bubbles
        dec_ex_d.valid   = issue_i.valid;
        dec_ex_d.illegal = issue_i.valid & illegal;
        dec_ex_d.rd_wren = issue_i.valid & known_op & (insn.r.rd != '0);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
            rd_wren_q <= 1'b0;
        end else begin
            valid_q   <= dec_ex_d.valid;
            illegal_q <= dec_ex_d.illegal;
            rd_wren_q <= dec_ex_d.rd_wren;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= dec_ex_d;
    end

    always_comb begin
        dec_ex_o         = data_q;
        dec_ex_o.valid   = valid_q;
        dec_ex_o.illegal = illegal_q;
        dec_ex_o.rd_wren = rd_wren_q;
    end

endmodule

//--- logic/rv_execute.sv
module rv_execute (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  rv_core_pkg::dec_ex_t dec_ex_i,
    output rv_core_pkg::ex_wb_t  ex_wb_o
);
    import rv_core_pkg::*;

    ex_wb_t             ex_wb_d;
    ex_wb_t             data_q;
    logic               valid_q;
    logic               illegal_q;
    logic               rd_wren_q;
    logic               fwd_ok;
    logic               fwd_rs1;
    logic               fwd_rs2;
    logic [xlen-1:0]    op_a;
    logic [xlen-1:0]    rs2_val;
    logic [xlen-1:0]    op_b;
    logic [shamt_w-1:0] shamt;

    // Previous result is usable only if it really writes a register
    assign fwd_ok  = ex_wb_o.valid & ~ex_wb_o.illegal & ex_wb_o.rd_wren &
                     (ex_wb_o.rd != '0);
    assign fwd_rs1 = fwd_ok & (ex_wb_o.rd == dec_ex_i.rs1);
    assign fwd_rs2 = fwd_ok & (ex_wb_o.rd == dec_ex_i.rs2);

    assign op_a    = fwd_rs1 ? ex_wb_o.result : dec_ex_i.rs1_data;
    assign rs2_val = fwd_rs2 ? ex_wb_o.result : dec_ex_i.rs2_data;
    assign op_b    = dec_ex_i.use_imm ? dec_ex_i.imm : rs2_val;
    assign shamt   = op_b[shamt_w-1:0];

    always_comb begin
        ex_wb_d         = '0;
        ex_wb_d.valid   = dec_ex_i.valid;
        ex_wb_d.illegal = dec_ex_i.illegal;
        ex_wb_d.rd_wren = dec_ex_i.rd_wren;
        ex_wb_d.rd      = dec_ex_i.rd;

        case (dec_ex_i.alu_op)
            alu_add:    ex_wb_d.result = op_a + op_b;
            alu_sub:    ex_wb_d.result = op_a - op_b;
            alu_sll:    ex_wb_d.result = op_a << shamt;
            alu_slt:    ex_wb_d.result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   ex_wb_d.result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:    ex_wb_d.result = op_a ^ op_b;
            alu_srl:    ex_wb_d.result = op_a >> shamt;
            // Sign bit fills from the left
            alu_sra:    ex_wb_d.result = $unsigned($signed(op_a) >>> shamt);
            alu_or:     ex_wb_d.result = op_a | op_b;
            alu_and:    ex_wb_d.result = op_a & op_b;
            alu_pass_b: ex_wb_d.result = op_b;
            default:    ex_wb_d.result = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
            rd_wren_q <= 1'b0;
        end else begin
            valid_q   <= ex_wb_d.valid;
            illegal_q <= ex_wb_d.illegal;
            rd_wren_q <= ex_wb_d.rd_wren;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= ex_wb_d;
    end

    always_comb begin
        ex_wb_o         = data_q;
        ex_wb_o.valid   = valid_q;
        ex_wb_o.illegal = illegal_q;
        ex_wb_o.rd_wren = rd_wren_q;
    end

endmodule

//--- logic/rv_writeback.sv
module rv_writeback (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  rv_core_pkg::ex_wb_t                ex_wb_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs1_addr_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs2_addr_i,
    output rv_core_pkg::rf_read_t              rf_read_o,
    output rv_core_pkg::retire_t               retire_o
);
    import rv_core_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs_q [1:num_regs-1];
    logic            wr_en;

    assign wr_en = ex_wb_i.valid & ~ex_wb_i.illegal & ex_wb_i.rd_wren &
                   (ex_wb_i.rd != '0);

    // Write-through so decode sees the value retiring this cycle
    function automatic logic [xlen-1:0] read_port(logic [reg_addr_w-1:0] addr);
        logic [xlen-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && (ex_wb_i.rd == addr)) begin
            data = ex_wb_i.result;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < num_regs; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[ex_wb_i.rd] <= ex_wb_i.result;
        end
    end

    always_comb begin
        rf_read_o.rs1_data = read_port(rs1_addr_i);
        rf_read_o.rs2_data = read_port(rs2_addr_i);
    end

    // Illegal words retire without a register write
    always_comb begin
        retire_o.valid   = ex_wb_i.valid;
        retire_o.illegal = ex_wb_i.illegal;
        retire_o.rd_wren = ex_wb_i.rd_wren & ~ex_wb_i.illegal;
        retire_o.rd      = ex_wb_i.rd;
        retire_o.result  = ex_wb_i.result;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Let assertion errors reach the testbench summary
output=$(./obj_dir/Vtb_rv_core +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

//--- sim/rv_core_checker.sv
module rv_core_checker (
    input logic                 clk_i,
    input logic                 rst_ni,
    input rv_core_pkg::issue_t  issue_i,
    input rv_core_pkg::retire_t retire_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Pipeline stays empty while reset is held
    retire_idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !retire_i.valid)
        else begin
            fail_count++;
            $error("retire valid seen while reset is asserted");
        end

    // Fixed two-cycle latency, bubbles included
    retire_follows_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
        retire_i.valid == $past(issue_i.valid, 2))
        else begin
            fail_count++;
            $error("retire valid does not match issue valid two cycles earlier");
        end

    no_write_to_x0: assert property (@(posedge clk_i) disable iff (!rst_ni)
        retire_i.rd_wren |-> (retire_i.rd != '0))
        else begin
            fail_count++;
            $error("register write retired with rd equal to zero");
        end

endmodule

bind rv_core_top rv_core_checker i_checker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .issue_i  (issue_i),
    .retire_i (retire_o)
);

//--- sim/rv_stim.txt
// valid insn ctrl result, one instruction per line, all hex
// ctrl is {illegal, rd_wren, rd[4:0]}; result is not checked for illegal words
1 00500093 21 00000005  // addi x1, x0, 5
1 FFD00113 22 FFFFFFFD  // addi x2, x0, -3
1 002081B3 23 00000002  // add  x3, x1, x2
1 40118233 24 FFFFFFFD  // sub  x4, x3, x1
0 00000000 00 00000000  // idle
1 800002B7 25 80000000  // lui  x5, 0x80000
1 4042D313 26 F8000000  // srai x6, x5, 4
1 0042D393 27 08000000  // srli x7, x5, 4
1 0012A433 28 00000001  // slt  x8, x5, x1
1 0012B4B3 29 00000000  // sltu x9, x5, x1
1 01F09513 2A 80000000  // slli x10, x1, 31
1 FFF14593 2B 00000002  // xori x11, x2, -1
1 7FF06613 2C 000007FF  // ori  x12, x0, 0x7ff
1 0F017693 2D 000000F0  // andi x13, x2, 0xf0
1 00012713 2E 00000001  // slti x14, x2, 0
1 FFF0B793 2F 00000001  // sltiu x15, x1, -1
1 00708013 00 0000000C  // addi x0, x1, 7
1 00000833 30 00000000  // add  x16, x0, x0
1 0000A883 51 00000000  // lw   x17, 0(x1), unsupported
1 02108933 52 00000000  // mul  x18, x1, x1, unsupported
1 012889B3 33 00000000  // add  x19, x17, x18
0 00000000 00 00000000  // idle
0 00000000 00 00000000  // idle
1 00B09A33 34 00000014  // sll  x20, x1, x11
1 40D35AB3 35 FFFFF800  // sra  x21, x6, x13
1 00D35B33 36 0000F800  // srl  x22, x6, x13
1 016AEBB3 37 FFFFF800  // or   x23, x21, x22
1 00CBCC33 38 FFFFFFFF  // xor  x24, x23, x12
1 004C7CB3 39 FFFFFFFD  // and  x25, x24, x4
1 00108093 21 00000006  // addi x1, x1, 1
1 00108093 21 00000007  // addi x1, x1, 1
1 40100D33 3A FFFFFFF9  // sub  x26, x0, x1

//--- sim/tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_core_pkg::*;

    localparam int max_lines   = 64;
    localparam int reset_len   = 10;
    localparam int drain_extra = 3;

    // One expected retirement, taken from a stimulus entry
    typedef struct packed {
        logic [15:0] idx;
        logic [6:0]  ctrl;
        logic [31:0] result;
    } expect_t;

    logic    clk_i;
    logic    rst_ni;
    issue_t  issue_i;
    retire_t retire_o;

    // Four words per entry: valid, insn, ctrl, result
    logic [31:0] stim_mem [0:4*max_lines-1];
    expect_t     exp_q [$];

    int num_lines       = 0;
    int timeout_limit   = 20;
    int cycle_count     = 0;
    int mismatch_errors = 0;
    int stray_errors    = 0;
    int timeout_errors  = 0;
    int load_errors     = 0;

    rv_core_top i_dut (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .issue_i  (issue_i),
        .retire_o (retire_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic drive_line(input int n);
        expect_t e;
        @(posedge clk_i);
        issue_i.valid <= stim_mem[4*n][0];
        issue_i.insn  <= stim_mem[4*n+1];
        if (stim_mem[4*n][0]) begin
            e.idx    = 16'(n);
            e.ctrl   = stim_mem[4*n+2][6:0];
            e.result = stim_mem[4*n+3];
            exp_q.push_back(e);
        end
    endtask

    task automatic finish_run();
        int    missing;
        int    asserts;
        int    total;
        string summary;
        missing = exp_q.size();
        asserts = i_dut.i_checker.fail_count;
        total   = mismatch_errors + stray_errors + timeout_errors + load_errors +
                  missing + asserts;
        summary = $sformatf("Errors: %0d mismatch, %0d unexpected, %0d missing,",
                            mismatch_errors, stray_errors, missing);
        $display("%s %0d timeout, %0d load, %0d assertion", summary, timeout_errors,
                 load_errors, asserts);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // Retirements are compared in issue order
    always @(negedge clk_i) begin
        expect_t head;
        if (rst_ni && retire_o.valid) begin
            if (exp_q.size() == 0) begin
                stray_errors++;
                $display("Retirement for rd %0d arrived with no instruction outstanding",
                         retire_o.rd);
            end else begin
                head = exp_q.pop_front();
                check_value($sformatf("entry %0d flags", head.idx), {25'b0, head.ctrl},
                            {25'b0, retire_o.illegal, retire_o.rd_wren, retire_o.rd});
                // Illegal words carry no defined result
                if (!head.ctrl[6]) begin
                    check_value($sformatf("entry %0d result", head.idx), head.result,
                                retire_o.result);
                end
            end
        end
    end

    // Watchdog, armed once reset is released
    initial begin
        wait (rst_ni === 1'b1);
        while (cycle_count < timeout_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        timeout_errors++;
        $display("Timeout after %0d cycles with %0d retirements still outstanding",
                 timeout_limit, exp_q.size());
        finish_run();
    end

    initial begin
        issue_i = '0;
        rst_ni  = 1'b0;

        // Unused entries get a valid column above 1
        for (int a = 0; a < 4*max_lines; a++) begin
            stim_mem[a] = {16'hdead, 16'(a)};
        end
        $readmemh("sim/rv_stim.txt", stim_mem);
        while ((num_lines < max_lines) && (stim_mem[4*num_lines] <= 32'd1)) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            load_errors++;
            $display("Stimulus file sim/rv_stim.txt held no usable entries");
        end
        timeout_limit = num_lines + 20;

        repeat (reset_len) @(posedge clk_i);
        rst_ni <= 1'b1;

        for (int n = 0; n < num_lines; n++) begin
            drive_line(n);
        end
        @(posedge clk_i);
        issue_i <= '0;

        // Drain the pipeline, then watch for stray retirements
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (drain_extra) @(posedge clk_i);
        finish_run();
    end

endmodule

//--- tb.f
logic/rv_core_pkg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_writeback.sv
logic/rv_core_top.sv
sim/rv_core_checker.sv
sim/tb_rv_core.sv
